/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, exit status 0 only on a passing log

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tb_axi_write_delayer \
  --Mdir obj_dir -o tb_axi_write_delayer
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_axi_write_delayer > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL, see sim.log"
  exit 1
fi

/* source/axi_delay_pkg.sv */
// Shared widths and stall constants for the write-path AXI delayer, imported by every RTL module
`default_nettype none

package axi_delay_pkg;

  // Bus field widths of the write channels
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned ID_WIDTH = 8;
  localparam int unsigned RESP_WIDTH = 2;

  // Payload widths of each channel as carried through a slice
  // AW holds the address above the ID
  localparam int unsigned AW_WIDTH = ADDR_WIDTH + ID_WIDTH;
  // W holds the data above the strobe
  localparam int unsigned W_WIDTH = DATA_WIDTH + STRB_WIDTH;
  // B holds the ID above the response
  localparam int unsigned B_WIDTH = ID_WIDTH + RESP_WIDTH;

  // The stall counter width bounds a random stall to 0..15 cycles
  localparam int unsigned DELAY_WIDTH = 4;

  // Stall length used while stall_random is low
  localparam logic [DELAY_WIDTH-1:0] FIXED_DELAY = 4'd3;

  // The random source is a 16-bit Galois LFSR with a maximal-length polynomial
  localparam int unsigned LFSR_WIDTH = 16;
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;

  // State codes of the per-slice stall FSM
  localparam int unsigned STATE_WIDTH = 2;
  // Waiting for an upstream beat
  localparam logic [STATE_WIDTH-1:0] IDLE = 2'd0;
  // Beat captured, timer running
  localparam logic [STATE_WIDTH-1:0] STALL = 2'd1;
  // Beat offered downstream until taken
  localparam logic [STATE_WIDTH-1:0] OFFER = 2'd2;

endpackage

`default_nettype wire

/* source/axi_write_delayer.sv */
// Top level of the write-path AXI delayer, stalling each AW, W and B beat between master and slave
`timescale 1ns/100ps
`default_nettype none

module axi_write_delayer import axi_delay_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // High selects a pseudo-random stall per beat, low the fixed stall
  input  wire logic                  stall_random,

  // Upstream AW from the master
  input  wire logic                  s_aw_valid,
  output logic                       s_aw_ready,
  input  wire logic [ADDR_WIDTH-1:0] s_aw_addr,
  input  wire logic [ID_WIDTH-1:0]   s_aw_id,

  // Upstream W from the master
  input  wire logic                  s_w_valid,
  output logic                       s_w_ready,
  input  wire logic [DATA_WIDTH-1:0] s_w_data,
  input  wire logic [STRB_WIDTH-1:0] s_w_strb,

  // Upstream B back to the master
  output logic                       s_b_valid,
  input  wire logic                  s_b_ready,
  output logic [ID_WIDTH-1:0]        s_b_id,
  output logic [RESP_WIDTH-1:0]      s_b_resp,

  // Downstream AW to the slave
  output logic                       m_aw_valid,
  input  wire logic                  m_aw_ready,
  output logic [ADDR_WIDTH-1:0]      m_aw_addr,
  output logic [ID_WIDTH-1:0]        m_aw_id,

  // Downstream W to the slave
  output logic                       m_w_valid,
  input  wire logic                  m_w_ready,
  output logic [DATA_WIDTH-1:0]      m_w_data,
  output logic [STRB_WIDTH-1:0]      m_w_strb,

  // Downstream B from the slave
  input  wire logic                  m_b_valid,
  output logic                       m_b_ready,
  input  wire logic [ID_WIDTH-1:0]   m_b_id,
  input  wire logic [RESP_WIDTH-1:0] m_b_resp
);

  // Packed payloads entering and leaving each slice
  logic [AW_WIDTH-1:0] aw_in;
  logic [AW_WIDTH-1:0] aw_out;
  logic [W_WIDTH-1:0]  w_in;
  logic [W_WIDTH-1:0]  w_out;
  logic [B_WIDTH-1:0]  b_in;
  logic [B_WIDTH-1:0]  b_out;

  assign aw_in = {s_aw_addr, s_aw_id};
  assign w_in = {s_w_data, s_w_strb};
  // B travels against the other two, from the slave side to the master side
  assign b_in = {m_b_id, m_b_resp};

  assign {m_aw_addr, m_aw_id} = aw_out;
  assign {m_w_data, m_w_strb} = w_out;
  assign {s_b_id, s_b_resp} = b_out;

  // The three channels run independently, each with its own LFSR seed
  delay_slice #(
    .WIDTH     (AW_WIDTH),
    .LFSR_SEED (16'hACE1)
  ) aw_slice (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_random (stall_random),
    .in_valid     (s_aw_valid),
    .in_ready     (s_aw_ready),
    .in_payload   (aw_in),
    .out_valid    (m_aw_valid),
    .out_ready    (m_aw_ready),
    .out_payload  (aw_out)
  );

  delay_slice #(
    .WIDTH     (W_WIDTH),
    .LFSR_SEED (16'h5A3C)
  ) w_slice (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_random (stall_random),
    .in_valid     (s_w_valid),
    .in_ready     (s_w_ready),
    .in_payload   (w_in),
    .out_valid    (m_w_valid),
    .out_ready    (m_w_ready),
    .out_payload  (w_out)
  );

  delay_slice #(
    .WIDTH     (B_WIDTH),
    .LFSR_SEED (16'h1D3B)
  ) b_slice (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_random (stall_random),
    .in_valid     (m_b_valid),
    .in_ready     (m_b_ready),
    .in_payload   (b_in),
    .out_valid    (s_b_valid),
    .out_ready    (s_b_ready),
    .out_payload  (b_out)
  );

endmodule

`default_nettype wire

/* source/delay_slice.sv */
// One delayed channel, a single-beat holding register steered by a stall FSM and a stall timer
`timescale 1ns/100ps
`default_nettype none

module delay_slice import axi_delay_pkg::*; #(
  parameter int unsigned           WIDTH     = 32,
  parameter logic [LFSR_WIDTH-1:0] LFSR_SEED = 16'hACE1
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             stall_random,
  input  wire logic             in_valid,
  output logic                  in_ready,
  input  wire logic [WIDTH-1:0] in_payload,
  output logic                  out_valid,
  input  wire logic             out_ready,
  output logic [WIDTH-1:0]      out_payload
);

  // Control shared by the FSM, the timer and the register below
  slice_ctrl_if ctrl ();

  // Held beat, written only on capture so it stays stable while offered
  logic [WIDTH-1:0] payload_q;

  stall_fsm stall_fsm_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .ctrl      (ctrl.fsm)
  );

  delay_timer #(
    .LFSR_SEED (LFSR_SEED)
  ) delay_timer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_random (stall_random),
    .ctrl         (ctrl.timer)
  );

  // The payload register takes the upstream beat on capture
  always_ff @(posedge clk) begin
    if (ctrl.capture) begin
      payload_q <= in_payload;
    end
  end

  assign out_payload = payload_q;
  assign out_valid = ctrl.hold_valid;

endmodule

`default_nettype wire

/* source/delay_timer.sv */
// Stall timer of one slice, a down-counter loaded with a fixed or LFSR-drawn stall length
`timescale 1ns/100ps
`default_nettype none

module delay_timer import axi_delay_pkg::*; #(
  // Each slice gets its own non-zero seed so the channels stall independently
  parameter logic [LFSR_WIDTH-1:0] LFSR_SEED = 16'hACE1
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   stall_random,
  slice_ctrl_if.timer ctrl
);

  logic [LFSR_WIDTH-1:0]  lfsr;
  logic [DELAY_WIDTH-1:0] count;
  // Set by the first load, so the idle zero count after reset is not taken as expiry
  logic                   armed;
  logic [DELAY_WIDTH-1:0] load_value;
  // Mode as it stood at the previous edge, which is the accepting edge when the load comes
  logic                   mode_q;

  // Random mode uses the low LFSR bits, giving 0 to 15 cycles
  assign load_value = mode_q ? lfsr[DELAY_WIDTH-1:0] : FIXED_DELAY;

  // A pending start overrides the expiry left over from the previous beat
  assign ctrl.timer_expired = armed && (count == '0) && !ctrl.timer_start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_q <= 1'b0;
    end else begin
      mode_q <= stall_random;
    end
  end

  // The Galois LFSR shifts right and folds the taps in when bit 0 falls out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr <= LFSR_SEED;
    end else if (lfsr[0]) begin
      lfsr <= {1'b0, lfsr[LFSR_WIDTH-1:1]} ^ LFSR_TAPS;
    end else begin
      lfsr <= {1'b0, lfsr[LFSR_WIDTH-1:1]};
    end
  end

  // Count down to zero and stay there until the next start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      armed <= 1'b0;
    end else if (ctrl.timer_start) begin
      count <= load_value;
      armed <= 1'b1;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/slice_ctrl_if.sv */
// Control bundle between the stall FSM, the stall timer and the payload register of one slice
`timescale 1ns/100ps
`default_nettype none

interface slice_ctrl_if;

  // One-cycle pulse that loads the payload register with the upstream beat
  logic capture;
  // One-cycle pulse, the cycle after capture, that loads the stall counter
  logic timer_start;
  // Level while the loaded stall has run out
  logic timer_expired;
  // Downstream valid of the held beat
  logic hold_valid;

  // The FSM sequences the slice
  modport fsm (
    output capture,
    output timer_start,
    output hold_valid,
    input  timer_expired
  );

  // The timer only reacts to a start and reports expiry
  modport timer (
    input  timer_start,
    output timer_expired
  );

  // View of the payload register and the output valid
  modport holder (
    input capture,
    input hold_valid
  );

endinterface

`default_nettype wire

/* source/stall_fsm.sv */
// Stall FSM of one slice, accepting a beat, waiting out the timer and offering the beat downstream
`timescale 1ns/100ps
`default_nettype none

module stall_fsm import axi_delay_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  wire logic   out_ready,
  slice_ctrl_if.fsm   ctrl
);

  logic [STATE_WIDTH-1:0] state;
  logic [STATE_WIDTH-1:0] state_next;
  // Capture delayed by one cycle so the timer loads one edge after acceptance
  logic start_q;

  // The slice takes a new beat only while empty
  assign in_ready = (state == IDLE);
  assign ctrl.capture = in_ready && in_valid;
  assign ctrl.timer_start = start_q;

  // Valid is raised in the same cycle the timer runs out, which puts it at E+1+L
  // and lets a zero-length stall show valid right after the timer load
  assign ctrl.hold_valid = ((state == STALL) && ctrl.timer_expired) || (state == OFFER);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (ctrl.capture) begin
          state_next = STALL;
        end
      end
      STALL: begin
        // A beat taken in its first valid cycle skips OFFER entirely
        if (ctrl.timer_expired) begin
          state_next = out_ready ? IDLE : OFFER;
        end
      end
      OFFER: begin
        // Hold valid and payload under back-pressure
        if (out_ready) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      start_q <= 1'b0;
    end else begin
      state <= state_next;
      start_q <= ctrl.capture;
    end
  end

endmodule

`default_nettype wire

/* test/tb_axi_write_delayer.sv */
// Testbench for the write-path AXI delayer, run with vlog.f, plays master and slave from a file
`timescale 1ns/100ps
`default_nettype none

module tb_axi_write_delayer import axi_delay_pkg::*; ();

  localparam int MAX_BEATS = 32;
  localparam int TIMEOUT = 200;
  // A fixed stall shows valid one load cycle plus the stall after acceptance
  localparam int FIXED_LATENCY = 1 + int'(FIXED_DELAY);
  // The longest random stall is 15 cycles and the load cycle adds one
  localparam int MAX_LATENCY = 1 << DELAY_WIDTH;
  // Acceptance cycle of a beat the master has not handed over yet
  localparam int NOT_ACCEPTED = 2147483647;

  logic clk;
  logic rst_n;
  logic stall_random;
  logic s_aw_valid;
  logic s_aw_ready;
  logic [ADDR_WIDTH-1:0] s_aw_addr;
  logic [ID_WIDTH-1:0] s_aw_id;
  logic s_w_valid;
  logic s_w_ready;
  logic [DATA_WIDTH-1:0] s_w_data;
  logic [STRB_WIDTH-1:0] s_w_strb;
  logic s_b_valid;
  logic s_b_ready;
  logic [ID_WIDTH-1:0] s_b_id;
  logic [RESP_WIDTH-1:0] s_b_resp;
  logic m_aw_valid;
  logic m_aw_ready;
  logic [ADDR_WIDTH-1:0] m_aw_addr;
  logic [ID_WIDTH-1:0] m_aw_id;
  logic m_w_valid;
  logic m_w_ready;
  logic [DATA_WIDTH-1:0] m_w_data;
  logic [STRB_WIDTH-1:0] m_w_strb;
  logic m_b_valid;
  logic m_b_ready;
  logic [ID_WIDTH-1:0] m_b_id;
  logic [RESP_WIDTH-1:0] m_b_resp;

  // Expected values hold one entry per stimulus line
  logic exp_mode [MAX_BEATS];
  logic [ADDR_WIDTH-1:0] exp_addr [MAX_BEATS];
  logic [ID_WIDTH-1:0] exp_id [MAX_BEATS];
  logic [DATA_WIDTH-1:0] exp_data [MAX_BEATS];
  logic [STRB_WIDTH-1:0] exp_strb [MAX_BEATS];
  logic [RESP_WIDTH-1:0] exp_resp [MAX_BEATS];
  // Cycle count just after the accepting edge of each upstream beat
  int aw_acc [MAX_BEATS];
  int w_acc [MAX_BEATS];
  int num_beats;
  int aw_seen;
  int w_seen;
  int b_seen;
  int cycle = 0;
  int seed = 45173;
  // IDs taken from downstream AW beats, waiting for their B answer
  logic [ID_WIDTH-1:0] b_id_q [$];

  axi_write_delayer axi_write_delayer_inst (
    .clk (clk), .rst_n (rst_n), .stall_random (stall_random),
    .s_aw_valid (s_aw_valid), .s_aw_ready (s_aw_ready),
    .s_aw_addr (s_aw_addr), .s_aw_id (s_aw_id),
    .s_w_valid (s_w_valid), .s_w_ready (s_w_ready),
    .s_w_data (s_w_data), .s_w_strb (s_w_strb),
    .s_b_valid (s_b_valid), .s_b_ready (s_b_ready),
    .s_b_id (s_b_id), .s_b_resp (s_b_resp),
    .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
    .m_aw_addr (m_aw_addr), .m_aw_id (m_aw_id),
    .m_w_valid (m_w_valid), .m_w_ready (m_w_ready),
    .m_w_data (m_w_data), .m_w_strb (m_w_strb),
    .m_b_valid (m_b_valid), .m_b_ready (m_b_ready),
    .m_b_id (m_b_id), .m_b_resp (m_b_resp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Outputs are sampled on the falling edge, where this count is stable
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic halt_with_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      halt_with_failure();
    end
  endtask

  task automatic check_latency(input string name, input int got, input logic random_mode);
    if (!random_mode && got != FIXED_LATENCY) begin
      $display("** Error: %s latency got %0h expected %0h", name, got, FIXED_LATENCY);
      halt_with_failure();
    end else if (random_mode && (got < 1 || got > MAX_LATENCY)) begin
      $display("** Error: %s latency got %0h expected 1 to %0h", name, got, MAX_LATENCY);
      halt_with_failure();
    end
  endtask

  task automatic check_aw(input logic [ADDR_WIDTH-1:0] got_addr,
                          input logic [ID_WIDTH-1:0] got_id,
                          input logic [ADDR_WIDTH-1:0] ref_addr,
                          input logic [ID_WIDTH-1:0] ref_id);
    if (got_addr !== ref_addr) begin
      $display("** Error: m_aw_addr got %h expected %h", got_addr, ref_addr);
      halt_with_failure();
    end else if (got_id !== ref_id) begin
      $display("** Error: m_aw_id got %h expected %h", got_id, ref_id);
      halt_with_failure();
    end
  endtask

  task automatic check_w(input logic [DATA_WIDTH-1:0] got_data,
                         input logic [STRB_WIDTH-1:0] got_strb,
                         input logic [DATA_WIDTH-1:0] ref_data,
                         input logic [STRB_WIDTH-1:0] ref_strb);
    if (got_data !== ref_data) begin
      $display("** Error: m_w_data got %h expected %h", got_data, ref_data);
      halt_with_failure();
    end else if (got_strb !== ref_strb) begin
      $display("** Error: m_w_strb got %h expected %h", got_strb, ref_strb);
      halt_with_failure();
    end
  endtask

  task automatic check_b(input logic [ID_WIDTH-1:0] got_id,
                         input logic [RESP_WIDTH-1:0] got_resp,
                         input logic [ID_WIDTH-1:0] ref_id,
                         input logic [RESP_WIDTH-1:0] ref_resp);
    if (got_id !== ref_id) begin
      $display("** Error: s_b_id got %h expected %h", got_id, ref_id);
      halt_with_failure();
    end else if (got_resp !== ref_resp) begin
      $display("** Error: s_b_resp got %h expected %h", got_resp, ref_resp);
      halt_with_failure();
    end
  endtask

  // Ready three cycles out of four on average
  function automatic logic pick_ready();
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic load_stimulus();
    int fd;
    int fields;
    string line;
    logic mode_v;
    logic [ADDR_WIDTH-1:0] addr_v;
    logic [ID_WIDTH-1:0] id_v;
    logic [DATA_WIDTH-1:0] data_v;
    logic [STRB_WIDTH-1:0] strb_v;
    logic [RESP_WIDTH-1:0] resp_v;
    num_beats = 0;
    fd = $fopen("test/write_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/write_stimulus.txt");
      halt_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      // Lines starting with a hash describe the columns
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h", mode_v, addr_v, id_v, data_v, strb_v, resp_v);
        if (fields != 6 || num_beats >= MAX_BEATS) begin
          $display("Stimulus line %0d is malformed or beyond the table size", num_beats);
          halt_with_failure();
        end
        exp_mode[num_beats] = mode_v;
        exp_addr[num_beats] = addr_v;
        exp_id[num_beats] = id_v;
        exp_data[num_beats] = data_v;
        exp_strb[num_beats] = strb_v;
        exp_resp[num_beats] = resp_v;
        num_beats++;
      end
    end
    $fclose(fd);
  endtask

  // Plays the downstream slave and the upstream B receiver, one pass per falling edge
  task automatic serve_downstream();
    logic aw_fire;
    logic aw_prev;
    logic w_fire;
    logic w_prev;
    logic mb_fire;
    logic sb_fire;
    logic [ID_WIDTH-1:0] fire_id;
    int b_sent;
    aw_fire = 1'b0;
    aw_prev = 1'b0;
    w_fire = 1'b0;
    w_prev = 1'b0;
    mb_fire = 1'b0;
    sb_fire = 1'b0;
    fire_id = '0;
    b_sent = 0;
    forever begin
      @(negedge clk);
      // Book the transfers of the last rising edge, and the slice must be open again
      if (aw_fire) begin
        check_bit("s_aw_ready", s_aw_ready, 1'b1);
        b_id_q.push_back(fire_id);
        aw_seen++;
      end
      if (w_fire) begin
        check_bit("s_w_ready", s_w_ready, 1'b1);
        w_seen++;
      end
      if (mb_fire) begin
        b_id_q.delete(0);
        b_sent++;
      end
      if (sb_fire) begin
        check_bit("m_b_ready", m_b_ready, 1'b1);
        b_seen++;
      end

      // A slice that holds an accepted beat keeps its upstream ready low
      if (aw_seen < num_beats && cycle >= aw_acc[aw_seen]) begin
        check_bit("s_aw_ready", s_aw_ready, 1'b0);
      end
      if (w_seen < num_beats && cycle >= w_acc[w_seen]) begin
        check_bit("s_w_ready", s_w_ready, 1'b0);
      end
      if (b_sent > b_seen) begin
        check_bit("m_b_ready", m_b_ready, 1'b0);
      end

      // Payload is compared on every valid cycle, which also catches a change under stall
      if (m_aw_valid) begin
        if (aw_seen >= num_beats) begin
          $display("An AW beat came out after the last stimulus line");
          halt_with_failure();
        end else begin
          if (!aw_prev) begin
            check_latency("m_aw_valid", cycle - aw_acc[aw_seen], exp_mode[aw_seen]);
          end
          check_aw(m_aw_addr, m_aw_id, exp_addr[aw_seen], exp_id[aw_seen]);
        end
      end
      aw_prev = m_aw_valid;
      m_aw_ready = pick_ready();
      aw_fire = m_aw_valid && m_aw_ready;
      fire_id = m_aw_id;

      if (m_w_valid) begin
        if (w_seen >= num_beats) begin
          $display("A W beat came out after the last stimulus line");
          halt_with_failure();
        end else begin
          if (!w_prev) begin
            check_latency("m_w_valid", cycle - w_acc[w_seen], exp_mode[w_seen]);
          end
          check_w(m_w_data, m_w_strb, exp_data[w_seen], exp_strb[w_seen]);
        end
      end
      w_prev = m_w_valid;
      m_w_ready = pick_ready();
      w_fire = m_w_valid && m_w_ready;

      // The slave answers each AW in order, the head of the queue stays put until taken
      m_b_valid = (b_id_q.size() > 0);
      if (m_b_valid) begin
        m_b_id = b_id_q[0];
        m_b_resp = exp_resp[b_sent];
      end
      mb_fire = m_b_valid && m_b_ready;

      if (s_b_valid) begin
        if (b_seen >= num_beats) begin
          $display("A B response came back after the last stimulus line");
          halt_with_failure();
        end else begin
          check_b(s_b_id, s_b_resp, exp_id[b_seen], exp_resp[b_seen]);
        end
      end
      s_b_ready = pick_ready();
      sb_fire = s_b_valid && s_b_ready;
    end
  endtask

  initial begin : master
    int waited;
    logic aw_wait;
    logic w_wait;
    rst_n = 1'b0;
    stall_random = 1'b0;
    s_aw_valid = 1'b0;
    s_aw_addr = '0;
    s_aw_id = '0;
    s_w_valid = 1'b0;
    s_w_data = '0;
    s_w_strb = '0;
    s_b_ready = 1'b0;
    m_aw_ready = 1'b0;
    m_w_ready = 1'b0;
    m_b_valid = 1'b0;
    m_b_id = '0;
    m_b_resp = '0;
    aw_seen = 0;
    w_seen = 0;
    b_seen = 0;
    for (int i = 0; i < MAX_BEATS; i++) begin
      aw_acc[i] = NOT_ACCEPTED;
      w_acc[i] = NOT_ACCEPTED;
    end
    load_stimulus();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // All slices come out of reset empty
    check_bit("m_aw_valid", m_aw_valid, 1'b0);
    check_bit("m_w_valid", m_w_valid, 1'b0);
    check_bit("s_b_valid", s_b_valid, 1'b0);
    check_bit("s_aw_ready", s_aw_ready, 1'b1);
    check_bit("s_w_ready", s_w_ready, 1'b1);
    check_bit("m_b_ready", m_b_ready, 1'b1);

    fork
      serve_downstream();
    join_none

    for (int t = 0; t < num_beats; t++) begin
      // Each beat starts on a fresh falling edge after the last acceptance
      @(negedge clk);
      stall_random = exp_mode[t];
      s_aw_valid = 1'b1;
      s_aw_addr = exp_addr[t];
      s_aw_id = exp_id[t];
      s_w_valid = 1'b1;
      s_w_data = exp_data[t];
      s_w_strb = exp_strb[t];
      aw_wait = 1'b1;
      w_wait = 1'b1;
      waited = 0;
      while (aw_wait || w_wait) begin
        // Ready seen here means the beat transfers on the coming rising edge
        if (aw_wait && s_aw_ready) begin
          aw_wait = 1'b0;
          aw_acc[t] = cycle + 1;
        end
        if (w_wait && s_w_ready) begin
          w_wait = 1'b0;
          w_acc[t] = cycle + 1;
        end
        @(negedge clk);
        if (!aw_wait) s_aw_valid = 1'b0;
        if (!w_wait) s_w_valid = 1'b0;
        // The mode counts only at the accepting edge, so flipping it now must not matter
        if (!aw_wait && !w_wait) begin
          stall_random = ~exp_mode[t];
        end
        waited++;
        if (waited > TIMEOUT) begin
          $display("Timeout: upstream handshake never came for beat %0d, %s %0b, %s %0b",
                   t, "AW pending", aw_wait, "W pending", w_wait);
          halt_with_failure();
        end
      end
    end

    waited = 0;
    while (b_seen < num_beats || w_seen < num_beats) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout: not every W beat and B response came through, W %0d B %0d of %0d",
                 w_seen, b_seen, num_beats);
        halt_with_failure();
      end
    end

    // Nothing may be left over once every beat is accounted for
    check_bit("m_aw_valid", m_aw_valid, 1'b0);
    check_bit("m_w_valid", m_w_valid, 1'b0);
    check_bit("s_b_valid", s_b_valid, 1'b0);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/write_stimulus.txt */
# Columns in hex: mode addr id data strb resp
# Mode 0 is the fixed stall and mode 1 the random stall
0 00001000 01 deadbeef f 0
0 00001004 02 01234567 3 1
0 00001008 03 89abcdef c 0
0 0000100c 04 a5a5a5a5 1 2
1 00002000 a5 cafef00d f 0
1 00002004 a6 0badc0de 8 3
1 00002008 a7 12345678 6 1
1 0000200c a8 fedcba98 f 0
0 80000000 ff ffffffff f 2
1 80000010 10 00000000 0 0
1 40000020 11 5a5a5a5a a 1
0 40000024 12 76543210 5 3
1 7ffffffc 13 c3c3c3c3 f 0
1 00000000 00 0f0f0f0f 9 2

/* vlog.f */
source/axi_delay_pkg.sv
source/slice_ctrl_if.sv
source/stall_fsm.sv
source/delay_timer.sv
source/delay_slice.sv
source/axi_write_delayer.sv
test/tb_axi_write_delayer.sv
